// File: rtl/hwcnn_macros.svh
`ifndef HWCNN_MACROS_SVH
`define HWCNN_MACROS_SVH

// Datapath widths
`define HWCNN_PIX_W 8      // Pixel and kernel tap
`define HWCNN_BIAS_W 20
`define HWCNN_ACC_W 24     // Accumulator and result
`define HWCNN_SHIFT_W 5

// Buffer depths as address widths
`define HWCNN_LINE_AW 9    // 512 pixels
`define HWCNN_BIAS_AW 7    // 128 bias words

`endif

// File: rtl/hwcnn_pkg.sv
`default_nettype none

`include "hwcnn_macros.svh"

package hwcnn_pkg;

	typedef logic signed [`HWCNN_PIX_W-1:0] pixel_t;
	typedef logic signed [`HWCNN_PIX_W-1:0] weight_t;
	typedef logic signed [`HWCNN_BIAS_W-1:0] bias_t;
	typedef logic signed [`HWCNN_ACC_W-1:0] acc_t;

	typedef logic [`HWCNN_LINE_AW-1:0] line_addr_t;
	typedef logic [`HWCNN_BIAS_AW-1:0] bias_addr_t;
	typedef logic [`HWCNN_SHIFT_W-1:0] shift_t;

	typedef enum logic [1:0] {
		OP_WRITE_BIAS,
		OP_WRITE_WEIGHT,
		OP_WRITE_LINE,
		OP_CONV
	} opcode_t;

	// One word from the instruction FIFO
	typedef struct packed {
		opcode_t op;
		line_addr_t line_addr;    // Also the tap index for OP_WRITE_WEIGHT
		line_addr_t line_len;
		bias_addr_t bias_addr;
		shift_t shift;
		logic pool;
		logic [`HWCNN_BIAS_W-1:0] data;
	} inst_t;

	localparam int inst_w = $bits(inst_t);

endpackage

`default_nettype wire

// File: rtl/sram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w #(
	parameter type T = logic [7:0],
	parameter int AW = 8
) (
	input wire clk,
	input wire wr_en,
	input wire [AW-1:0] wr_addr,
	input wire T wr_data,
	input wire [AW-1:0] rd_addr,
	input wire rd_en,
	output T rd_data
);

	T mem [2**AW];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];  // Holds when rd_en is low
	end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire inst_t instruct,
	input wire inst_empty,
	input wire run_done,
	output logic inst_req,
	output logic bias_wr_en,
	output bias_addr_t bias_wr_addr,
	output bias_t bias_wr_data,
	output logic line_wr_en,
	output line_addr_t line_wr_addr,
	output pixel_t line_wr_data,
	output weight_t taps [3],
	output logic run_start,
	output line_addr_t run_addr,
	output line_addr_t run_len,
	output bias_addr_t run_bias_addr,
	output shift_t run_shift,
	output logic run_pool,
	output logic busy
);

	logic take;                 // FIFO word valid on instruct
	logic [1:0] tap_sel;
	line_addr_t cfg_addr;
	line_addr_t cfg_len;
	bias_addr_t cfg_bias_addr;
	shift_t cfg_shift;
	logic cfg_pool;

	//////////////////////////////
	// Fetch

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_req <= 1'b0;
			take <= 1'b0;
		end else begin
			inst_req <= !busy && !inst_req && !take && !inst_empty;
			take <= inst_req;
		end
	end

	//////////////////////////////
	// Decode

	assign tap_sel = instruct.line_addr[1:0];

	assign bias_wr_en = take && instruct.op == OP_WRITE_BIAS;
	assign bias_wr_addr = instruct.bias_addr;
	assign bias_wr_data = instruct.data;
	assign line_wr_en = take && instruct.op == OP_WRITE_LINE;
	assign line_wr_addr = instruct.line_addr;
	assign line_wr_data = instruct.data[$bits(pixel_t)-1:0];

	assign run_start = take && instruct.op == OP_CONV;

	// Start cycle sees the new fields before they are latched
	assign run_addr = run_start ? instruct.line_addr : cfg_addr;
	assign run_len = run_start ? instruct.line_len : cfg_len;
	assign run_bias_addr = run_start ? instruct.bias_addr : cfg_bias_addr;
	assign run_shift = run_start ? instruct.shift : cfg_shift;
	assign run_pool = run_start ? instruct.pool : cfg_pool;

	always_ff @(posedge clk) begin
		if (rst) begin
			taps <= '{default: '0};
			cfg_addr <= '0;
			cfg_len <= '0;
			cfg_bias_addr <= '0;
			cfg_shift <= '0;
			cfg_pool <= 1'b0;
			busy <= 1'b0;
		end else begin
			if (take && instruct.op == OP_WRITE_WEIGHT && tap_sel != 2'd3)
				taps[tap_sel] <= instruct.data[$bits(weight_t)-1:0];
			if (run_start) begin
				cfg_addr <= instruct.line_addr;
				cfg_len <= instruct.line_len;
				cfg_bias_addr <= instruct.bias_addr;
				cfg_shift <= instruct.shift;
				cfg_pool <= instruct.pool;
				busy <= 1'b1;
			end else if (run_done) begin
				busy <= 1'b0;  // Reopens the fetch
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/line_reader.sv
`timescale 1ns/1ps
`default_nettype none

module line_reader import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire run_start,
	input wire line_addr_t run_addr,
	input wire line_addr_t run_len,
	input wire stall,
	input wire pixel_t rd_data,
	output line_addr_t rd_addr,
	output logic rd_en,
	output logic win_valid,
	output logic win_last,
	output pixel_t window [3]
);

	line_addr_t rd_ptr;     // Next address to read
	line_addr_t rd_left;    // Reads still to issue
	line_addr_t win_left;   // Windows still to emit
	logic dv;               // rd_data holds a fresh pixel
	logic [1:0] fill;
	pixel_t px_old;
	pixel_t px_mid;

	assign rd_addr = run_start ? run_addr : rd_ptr;
	assign rd_en = run_start || (!stall && rd_left != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			rd_left <= '0;
			win_left <= '0;
			dv <= 1'b0;
			fill <= 2'd0;
		end else begin
			if (rd_en) begin
				rd_ptr <= rd_addr + 1'b1;
				rd_left <= (run_start ? run_len : rd_left) - 1'b1;
			end
			if (run_start || !stall)
				dv <= rd_en;
			if (run_start) begin
				fill <= 2'd0;
				win_left <= run_len - 2'd2;
			end else if (!stall && dv) begin
				if (fill != 2'd2)
					fill <= fill + 1'b1;
				if (win_valid)
					win_left <= win_left - 1'b1;
			end
		end
	end

	// Two older pixels, the newest comes straight from the buffer
	always_ff @(posedge clk) begin
		if (!stall && dv) begin
			px_old <= px_mid;
			px_mid <= rd_data;
		end
	end

	assign win_valid = dv && fill == 2'd2;
	assign win_last = win_valid && win_left == 'd1;
	assign window = '{px_old, px_mid, rd_data};

endmodule

`default_nettype wire

// File: rtl/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "hwcnn_macros.svh"

module conv_pe import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire stall,
	input wire win_valid,
	input wire win_last,
	input wire pixel_t window [3],
	input wire weight_t taps [3],
	input wire bias_t bias,
	input wire shift_t shift,
	output logic pe_valid,
	output logic pe_last,
	output acc_t pe_value
);

	logic signed [2*`HWCNN_PIX_W-1:0] prod [3];
	logic s1_valid;
	logic s1_last;
	acc_t sum;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			pe_valid <= 1'b0;
			pe_last <= 1'b0;
		end else if (!stall) begin
			s1_valid <= win_valid;
			s1_last <= win_last;
			pe_valid <= s1_valid;
			pe_last <= s1_last;
		end
	end

	// Products, then bias add
	always_comb sum = acc_t'(prod[0]) + acc_t'(prod[1]) + acc_t'(prod[2]) + acc_t'(bias);

	always_ff @(posedge clk) begin
		if (!stall) begin
			for (int k = 0; k < 3; k++)
				prod[k] <= window[k] * taps[k];
			pe_value <= sum >>> shift;  // Arithmetic, keeps sign
		end
	end

endmodule

`default_nettype wire

// File: rtl/pool_out.sv
`timescale 1ns/1ps
`default_nettype none

module pool_out import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire pe_valid,
	input wire pe_last,
	input wire acc_t pe_value,
	input wire pool,
	input wire result_ready,
	output logic stall,
	output logic result_valid,
	output acc_t result_data,
	output logic run_done
);

	acc_t held;          // First value of a pair
	logic have;
	logic out_last;      // Output register holds the final result
	logic drop_pend;     // Odd tail was dropped
	logic take_in;
	logic emit;

	assign stall = result_valid && !result_ready;
	assign take_in = pe_valid && !stall;
	assign emit = take_in && (!pool || have);

	// Done on final accept, or after a drop once the output drains
	assign run_done = (result_valid && result_ready && out_last) || (drop_pend && !stall);

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			out_last <= 1'b0;
			have <= 1'b0;
			drop_pend <= 1'b0;
		end else begin
			if (emit)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0;
			if (emit)
				out_last <= pe_last;
			if (take_in && pool)
				have <= !have && !pe_last;
			if (take_in && pool && !have && pe_last)
				drop_pend <= 1'b1;
			else if (run_done)
				drop_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in && pool && !have)
			held <= pe_value;
		if (emit)
			result_data <= (pool && held > pe_value) ? held : pe_value;
	end

endmodule

`default_nettype wire

// File: rtl/hwcnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_top import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire inst_t instruct,
	input wire inst_empty,
	output logic inst_req,
	input wire result_ready,
	output logic result_valid,
	output acc_t result_data,
	output logic busy
);

	logic bias_wr_en;
	bias_addr_t bias_wr_addr;
	bias_t bias_wr_data;
	logic line_wr_en;
	line_addr_t line_wr_addr;
	pixel_t line_wr_data;
	weight_t taps [3];

	logic run_start;
	line_addr_t run_addr;
	line_addr_t run_len;
	bias_addr_t run_bias_addr;
	shift_t run_shift;
	logic run_pool;
	logic run_done;

	bias_t bias;
	line_addr_t line_rd_addr;
	logic line_rd_en;
	pixel_t line_rd_data;

	logic stall;             // Back-pressure to every stage
	logic win_valid;
	logic win_last;
	pixel_t window [3];
	logic pe_valid;
	logic pe_last;
	acc_t pe_value;

	//////////////////////////////
	// Control and storage

	inst_decoder i_inst_decoder (
		.clk(clk),
		.rst(rst),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.run_done(run_done),
		.inst_req(inst_req),
		.bias_wr_en(bias_wr_en),
		.bias_wr_addr(bias_wr_addr),
		.bias_wr_data(bias_wr_data),
		.line_wr_en(line_wr_en),
		.line_wr_addr(line_wr_addr),
		.line_wr_data(line_wr_data),
		.taps(taps),
		.run_start(run_start),
		.run_addr(run_addr),
		.run_len(run_len),
		.run_bias_addr(run_bias_addr),
		.run_shift(run_shift),
		.run_pool(run_pool),
		.busy(busy)
	);

	// One bias word per run, held on rd_data
	sram_1r1w #(.T(bias_t), .AW($bits(bias_addr_t))) bias_buf (
		.clk(clk),
		.wr_en(bias_wr_en),
		.wr_addr(bias_wr_addr),
		.wr_data(bias_wr_data),
		.rd_addr(run_bias_addr),
		.rd_en(run_start),
		.rd_data(bias)
	);

	sram_1r1w #(.T(pixel_t), .AW($bits(line_addr_t))) line_buf (
		.clk(clk),
		.wr_en(line_wr_en),
		.wr_addr(line_wr_addr),
		.wr_data(line_wr_data),
		.rd_addr(line_rd_addr),
		.rd_en(line_rd_en),
		.rd_data(line_rd_data)
	);

	//////////////////////////////
	// Datapath

	line_reader i_line_reader (
		.clk(clk),
		.rst(rst),
		.run_start(run_start),
		.run_addr(run_addr),
		.run_len(run_len),
		.stall(stall),
		.rd_data(line_rd_data),
		.rd_addr(line_rd_addr),
		.rd_en(line_rd_en),
		.win_valid(win_valid),
		.win_last(win_last),
		.window(window)
	);

	conv_pe i_conv_pe (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.win_valid(win_valid),
		.win_last(win_last),
		.window(window),
		.taps(taps),
		.bias(bias),
		.shift(run_shift),
		.pe_valid(pe_valid),
		.pe_last(pe_last),
		.pe_value(pe_value)
	);

	pool_out i_pool_out (
		.clk(clk),
		.rst(rst),
		.pe_valid(pe_valid),
		.pe_last(pe_last),
		.pe_value(pe_value),
		.pool(run_pool),
		.result_ready(result_ready),
		.stall(stall),
		.result_valid(result_valid),
		.result_data(result_data),
		.run_done(run_done)
	);

endmodule

`default_nettype wire

// File: test/hwcnn_props.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_props import hwcnn_pkg::*; (
	input wire clk,
	input wire rst,
	input wire inst_req,
	input wire inst_empty,
	input wire busy,
	input wire result_valid,
	input wire result_ready,
	input wire acc_t result_data
);

	// Request decided on the previous cycle's FIFO state
	req_when_idle: assert property (@(posedge clk) disable iff (rst)
		inst_req |-> !busy && !$past(inst_empty))
		else $error("inst_req while busy or with an empty FIFO");

	result_held: assert property (@(posedge clk) disable iff (rst)
		result_valid && !result_ready |=> result_valid && $stable(result_data))
		else $error("result changed under back-pressure");

	result_in_run: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> busy)
		else $error("result_valid outside a run");

endmodule

bind hwcnn_top hwcnn_props i_hwcnn_props (
	.clk(clk),
	.rst(rst),
	.inst_req(inst_req),
	.inst_empty(inst_empty),
	.busy(busy),
	.result_valid(result_valid),
	.result_ready(result_ready),
	.result_data(result_data)
);

`default_nettype wire

// File: test/hwcnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_tb import hwcnn_pkg::*; ();

	typedef acc_t acc_list_t [$];

	// Sum of 4 * (len + 10) over the seven runs, plus room for line loading
	localparam int TIMEOUT = 4 * (151 + 7 * 10) + 1000;

	logic clk;
	logic rst;
	inst_t instruct;
	logic inst_empty;
	logic inst_req;
	logic result_ready;
	logic result_valid;
	acc_t result_data;
	logic busy;

	logic [inst_w-1:0] inst_q [$];   // Instruction FIFO model
	acc_t exp_q [$];
	int cnt_q [$];                   // Expected result count per run
	pixel_t ref_line [2**$bits(line_addr_t)];
	bias_t ref_bias [2**$bits(bias_addr_t)];
	weight_t ref_taps [3];
	int unsigned lcg_state = 46497;
	logic bp_on = 1'b0;              // Random result_ready
	logic was_busy = 1'b0;
	int n_rx = 0;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	hwcnn_top i_hwcnn_top (
		.clk(clk),
		.rst(rst),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.inst_req(inst_req),
		.result_ready(result_ready),
		.result_valid(result_valid),
		.result_data(result_data),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Stimulus helpers

	function automatic int unsigned rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;  // Low bits cycle too fast
	endfunction

	// Expected results of one run from the stored line, taps and bias
	function automatic acc_list_t conv_line(input line_addr_t addr, input int len,
			input bias_addr_t ba, input shift_t sh, input logic pool);
		acc_list_t vals;
		acc_list_t res;
		int sum;
		for (int i = 0; i < len - 2; i++) begin
			sum = int'(ref_bias[ba]);
			for (int k = 0; k < 3; k++)
				sum += int'(ref_taps[k]) * int'(ref_line[line_addr_t'(addr + i + k)]);
			vals.push_back(acc_t'(sum >>> sh));
		end
		if (!pool)
			return vals;
		for (int n = 0; n + 1 < vals.size(); n += 2)
			res.push_back(vals[n] > vals[n + 1] ? vals[n] : vals[n + 1]);
		return res;  // Odd tail dropped
	endfunction

	task automatic put_inst(input opcode_t op, input line_addr_t la, input line_addr_t ll,
			input bias_addr_t ba, input shift_t sh, input logic pool, input bias_t data);
		inst_t w;
		w = '{op: op, line_addr: la, line_len: ll, bias_addr: ba, shift: sh,
			pool: pool, data: data};
		inst_q.push_back(w);
	endtask

	task automatic load_line(input line_addr_t addr, input int len);
		pixel_t px;
		for (int i = 0; i < len; i++) begin
			px = pixel_t'(rand_next());
			ref_line[line_addr_t'(addr + i)] = px;
			put_inst(OP_WRITE_LINE, line_addr_t'(addr + i), '0, '0, '0, 1'b0, bias_t'(px));
		end
	endtask

	task automatic load_taps();
		weight_t w;
		for (int k = 0; k < 3; k++) begin
			w = weight_t'(rand_next());
			ref_taps[k] = w;
			put_inst(OP_WRITE_WEIGHT, line_addr_t'(k), '0, '0, '0, 1'b0, bias_t'(w));
		end
	endtask

	task automatic load_bias(input bias_addr_t ba, input bias_t b);
		ref_bias[ba] = b;
		put_inst(OP_WRITE_BIAS, '0, '0, ba, '0, 1'b0, b);
	endtask

	task automatic start_conv(input line_addr_t addr, input int len, input bias_addr_t ba,
			input shift_t sh, input logic pool);
		acc_list_t vals;
		vals = conv_line(addr, len, ba, sh, pool);
		foreach (vals[i])
			exp_q.push_back(vals[i]);
		cnt_q.push_back(vals.size());
		put_inst(OP_CONV, addr, line_addr_t'(len), ba, sh, pool, '0);
	endtask

	task automatic wait_idle();
		do
			@(negedge clk);
		while (inst_q.size() != 0 || cnt_q.size() != 0 || busy);
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		$display("Test %0d %s: %s", tests, name, errors == mark ? "ok" : "errors");
	endtask

	//////////////////////////////
	// Checks

	task automatic check_result(input acc_t got, input acc_t want);
		checks++;
		if (got !== want) begin
			$display("FAIL at %0t ns: result %0d, expected %0d", $time, got, want);
			errors++;
		end
	endtask

	task automatic check_count(input acc_t got, input acc_t want);
		checks++;
		if (got !== want) begin
			$display("FAIL at %0t ns: run gave %0d results, expected %0d", $time, got, want);
			errors++;
		end
	endtask

	// FIFO model, the word follows the request by one cycle
	always @(negedge clk) begin
		if (inst_req) begin
			if (inst_q.size() == 0) begin
				$display("inst_req raised at %0t ns with an empty instruction FIFO", $time);
				errors++;
			end else begin
				instruct = inst_t'(inst_q.pop_front());
			end
		end
		inst_empty = inst_q.size() == 0;
	end

	always @(negedge clk)
		result_ready = bp_on ? (rand_next() & 1) != 0 : 1'b1;

	always @(posedge clk) begin
		if (!rst && result_valid && result_ready) begin
			if (exp_q.size() == 0) begin
				$display("Extra result %0d at %0t ns with nothing expected", result_data, $time);
				errors++;
			end else begin
				check_result(result_data, exp_q.pop_front());
			end
			n_rx++;
		end
	end

	// Run end, count the results of the finished run
	always @(negedge clk) begin
		if (was_busy && !busy) begin
			if (cnt_q.size() == 0) begin
				$display("Run ended at %0t ns with no run queued", $time);
				errors++;
			end else begin
				check_count(acc_t'(n_rx), acc_t'(cnt_q.pop_front()));
			end
			n_rx = 0;
		end
		was_busy = busy;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, a run did not finish", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Tests

	initial begin
		int mark;
		rst = 1'b1;
		instruct = '0;
		inst_empty = 1'b1;
		result_ready = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		mark = errors;
		load_line(0, 20);
		load_taps();
		load_bias(3, bias_t'(rand_next()));
		start_conv(0, 20, 3, 0, 1'b0);
		wait_idle();
		end_test("unpooled line of 20", mark);

		mark = errors;
		// Below -49152, so every sum is negative
		load_bias(9, bias_t'(-65536) - bias_t'(rand_next() & 16'hffff));
		start_conv(0, 20, 9, 4, 1'b0);
		wait_idle();
		end_test("bias entry and shift", mark);

		mark = errors;
		start_conv(0, 15, 3, 1, 1'b1);
		start_conv(0, 16, 9, 2, 1'b1);
		wait_idle();
		end_test("pooled odd and even", mark);

		mark = errors;
		load_line(100, 40);
		@(posedge clk);
		bp_on = 1'b1;
		start_conv(100, 40, 3, 0, 1'b0);
		wait_idle();
		@(posedge clk);
		bp_on = 1'b0;
		end_test("back-pressure on 40", mark);

		mark = errors;
		start_conv(0, 20, 3, 0, 1'b0);
		do
			@(negedge clk);
		while (!busy);
		repeat (5) @(negedge clk);  // FIFO stays empty
		load_taps();
		start_conv(0, 20, 3, 1, 1'b0);
		wait_idle();
		end_test("taps rewritten between runs", mark);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && exp_q.size() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/hwcnn_pkg.sv
rtl/sram_1r1w.sv
rtl/inst_decoder.sv
rtl/line_reader.sv
rtl/conv_pe.sv
rtl/pool_out.sv
rtl/hwcnn_top.sv
test/hwcnn_props.sv
test/hwcnn_tb.sv

// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal -j 0
TOP     = hwcnn_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
SRCS    = $(shell grep -v '^+' $(FLIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf $(OBJ_DIR)
